// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - rtl/exec_isa_pkg.sv
  - rtl/exec_pipe_pkg.sv
  - rtl/exec_int_unit.sv
  - rtl/exec_branch_unit.sv
  - rtl/exec_sequencer.sv
  - rtl/exec_store_beats.sv
  - rtl/exec_stage_top.sv
  - target: simulation
    files:
      - sim/tb_exec_stage.sv

// File: filelist.f
+incdir+include
rtl/exec_isa_pkg.sv
rtl/exec_pipe_pkg.sv
rtl/exec_int_unit.sv
rtl/exec_branch_unit.sv
rtl/exec_sequencer.sv
rtl/exec_store_beats.sv
rtl/exec_stage_top.sv
sim/tb_exec_stage.sv

// File: include/exec_defines.svh
// Widths are fixed for the 32-bit core; the data bus is half the register width
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Register and address width
`define EXEC_XLEN 32

// Data-bus word width, one beat
`define EXEC_BUS_W 16

// Register index of the stack pointer
`define EXEC_SP_IDX 1

// Call frame holds the return address and the saved frame pointer
`define EXEC_FRAME_BYTES 8
`define EXEC_SLOT_BYTES 4

`endif

// File: rtl/exec_branch_unit.sv
// Branches read the flags of the last accepted cmp; flags are not forwarded within a cycle
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_branch_unit (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        accept_i,
  input  exec_pipe_pkg::exec_step_e   step_i,
  input  exec_pipe_pkg::exec_issue_t  issue_i,
  output logic                        taken_o,
  output exec_pipe_pkg::exec_branch_t branch_o
);
  import exec_pipe_pkg::*;
  import exec_isa_pkg::*;

  localparam int MSB = `EXEC_XLEN - 1;

  exec_cc_t              cc_d;
  exec_cc_t              cc_q;
  exec_branch_t          br_d;
  exec_branch_t          br_q;
  logic [`EXEC_XLEN-1:0] a;
  logic [`EXEC_XLEN-1:0] b;
  logic [`EXEC_XLEN-1:0] diff_ab;
  logic [`EXEC_XLEN-1:0] diff_ba;
  logic [`EXEC_XLEN-1:0] pcrel_target;
  logic [`EXEC_XLEN-1:0] call_tgt_q;

  assign a = issue_i.reg_a;
  assign b = issue_i.reg_b;
  assign diff_ab = a - b;
  assign diff_ba = b - a;

  // With differing signs the negative operand is the smaller one
  assign cc_d.eq = (a == b);
  assign cc_d.lt = (a[MSB] ^ b[MSB]) ? a[MSB] : diff_ab[MSB];
  assign cc_d.gt = (a[MSB] ^ b[MSB]) ? b[MSB] : diff_ba[MSB];
  assign cc_d.ltu = (a < b);
  assign cc_d.gtu = (a > b);

  // Offset counts half-words from the next instruction
  assign pcrel_target = issue_i.pc + `EXEC_XLEN'(2)
                      + {{(`EXEC_XLEN-11){issue_i.imm.br[9]}}, issue_i.imm.br, 1'b0};

  always_comb
  begin
    br_d.taken = 1'b0;
    br_d.target = pcrel_target;
    if (accept_i && step_i == STEP_FRAME2)
    begin
      br_d.taken = 1'b1;
      br_d.target = call_tgt_q;
    end
    else if (accept_i && step_i == STEP_READY)
    begin
      case (issue_i.op)
        OP_BEQ:  br_d.taken = cc_q.eq;
        OP_BNE:  br_d.taken = !cc_q.eq;
        OP_BLT:  br_d.taken = cc_q.lt;
        OP_BGT:  br_d.taken = cc_q.gt;
        OP_BLTU: br_d.taken = cc_q.ltu;
        OP_BGTU: br_d.taken = cc_q.gtu;
        OP_BLE:  br_d.taken = cc_q.eq | cc_q.lt;
        OP_BGE:  br_d.taken = cc_q.eq | cc_q.gt;
        OP_BLEU: br_d.taken = cc_q.eq | cc_q.ltu;
        OP_BGEU: br_d.taken = cc_q.eq | cc_q.gtu;
        OP_JMP:
        begin
          br_d.taken = 1'b1;
          br_d.target = a;
        end
        OP_JMPA:
        begin
          br_d.taken = 1'b1;
          br_d.target = issue_i.operand;
        end
        default: br_d.taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cc_q <= '0;
      br_q <= '0;
    end
    else
    begin
      br_q <= br_d;
      if (accept_i && step_i == STEP_READY && issue_i.op == OP_CMP)
        cc_q <= cc_d;
    end
  end

  // Call target, used one cycle later with the second frame record
  always_ff @(posedge clk_i)
  begin
    if (accept_i && step_i == STEP_READY)
      call_tgt_q <= (issue_i.op == OP_JSRA) ? issue_i.operand : a;
  end

  assign branch_o = br_q;
  assign taken_o = br_q.taken;

endmodule

// File: rtl/exec_int_unit.sv
// Shift amounts use all of reg_b, so amounts above 31 fill; divide and modulo give empty records
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_int_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       accept_i,
  input  exec_pipe_pkg::exec_step_e  step_i,
  input  exec_pipe_pkg::exec_issue_t issue_i,
  output exec_pipe_pkg::exec_wb_t    wb_o
);
  import exec_pipe_pkg::*;
  import exec_isa_pkg::*;

  exec_wb_t              wb_d;
  exec_wb_t              wb_q;
  logic [`EXEC_XLEN-1:0] a;
  logic [`EXEC_XLEN-1:0] b;
  logic [`EXEC_XLEN-1:0] step_val;
  logic [`EXEC_XLEN-1:0] frame_sp_q;
  logic [`EXEC_XLEN-1:0] frame_fp_q;
  logic [`EXEC_XLEN-1:0] frame_pc_q;

  assign a = issue_i.reg_a;
  assign b = issue_i.reg_b;
  assign step_val = {{(`EXEC_XLEN-8){1'b0}}, issue_i.imm.step.amount};

  always_comb
  begin
    wb_d = '0;
    wb_d.valid = 1'b1;
    wb_d.idx0 = issue_i.dst0;
    wb_d.idx1 = issue_i.dst1;
    wb_d.pc = issue_i.pc;
    case (step_i)
      STEP_FRAME2:
      begin
        // Second frame slot takes the caller's fp
        wb_d.pc = frame_pc_q;
        wb_d.we0 = 1'b1;
        wb_d.idx0 = exec_ridx_t'(`EXEC_SP_IDX);
        wb_d.res0 = frame_sp_q - `EXEC_SLOT_BYTES;
        wb_d.mem_wr = 1'b1;
        wb_d.mem_addr = frame_sp_q - `EXEC_SLOT_BYTES;
        wb_d.mem_data = frame_fp_q;
      end
      STEP_RET2:
      begin
        wb_d.pc = frame_pc_q;
        wb_d.mem_rd = 1'b1;
        wb_d.mem_addr = frame_sp_q + `EXEC_SLOT_BYTES;
      end
      default:
      begin
        wb_d.we0 = 1'b1;
        case (issue_i.op)
          OP_ADD_L: wb_d.res0 = a + b;
          OP_SUB_L: wb_d.res0 = a - b;
          OP_AND:   wb_d.res0 = a & b;
          OP_OR:    wb_d.res0 = a | b;
          OP_XOR:   wb_d.res0 = a ^ b;
          OP_ASHL:  wb_d.res0 = a << b;
          OP_ASHR:  wb_d.res0 = $signed(a) >>> b;
          OP_LSHR:  wb_d.res0 = a >> b;
          OP_MUL_L: wb_d.res0 = a * b;
          OP_NEG:   wb_d.res0 = -b;
          OP_NOT:   wb_d.res0 = ~b;
          OP_MOV:   wb_d.res0 = b;
          OP_SEX_B: wb_d.res0 = {{(`EXEC_XLEN-8){b[7]}}, b[7:0]};
          OP_SEX_S: wb_d.res0 = {{(`EXEC_XLEN-16){b[15]}}, b[15:0]};
          OP_ZEX_B: wb_d.res0 = {{(`EXEC_XLEN-8){1'b0}}, b[7:0]};
          OP_ZEX_S: wb_d.res0 = {{(`EXEC_XLEN-16){1'b0}}, b[15:0]};
          OP_LDI_B, OP_LDI_S, OP_LDI_L: wb_d.res0 = issue_i.operand;
          OP_INC:   wb_d.res0 = a + step_val;
          OP_DEC:   wb_d.res0 = a - step_val;
          OP_LDA_B, OP_LDA_S, OP_LDA_L:
          begin
            wb_d.mem_rd = 1'b1;
            wb_d.mem_addr = issue_i.operand;
          end
          OP_LD_B, OP_LD_S, OP_LD_L:
          begin
            wb_d.mem_rd = 1'b1;
            wb_d.mem_addr = b;
          end
          OP_LDO_B, OP_LDO_S, OP_LDO_L:
          begin
            wb_d.mem_rd = 1'b1;
            wb_d.mem_addr = issue_i.operand + b;
          end
          OP_PUSH:
          begin
            wb_d.res0 = a - `EXEC_SLOT_BYTES;
            wb_d.mem_wr = 1'b1;
            wb_d.mem_addr = a - `EXEC_SLOT_BYTES;
            wb_d.mem_data = b;
          end
          OP_POP:
          begin
            // Loaded word goes to the second register, the pointer to the first
            wb_d.mem_rd = 1'b1;
            wb_d.mem_addr = a;
            wb_d.we1 = 1'b1;
            wb_d.res1 = a - `EXEC_SLOT_BYTES;
            wb_d.idx0 = issue_i.dst1;
            wb_d.idx1 = issue_i.dst0;
          end
          OP_JSR, OP_JSRA:
          begin
            wb_d.idx0 = exec_ridx_t'(`EXEC_SP_IDX);
            wb_d.res0 = issue_i.sp - `EXEC_FRAME_BYTES;
            wb_d.mem_wr = 1'b1;
            wb_d.mem_addr = issue_i.sp - `EXEC_FRAME_BYTES;
            wb_d.mem_data = issue_i.pc + (issue_i.op == OP_JSRA ? `EXEC_XLEN'(6) : `EXEC_XLEN'(2));
          end
          OP_RET:
          begin
            wb_d.idx0 = exec_ridx_t'(`EXEC_SP_IDX);
            wb_d.res0 = issue_i.sp + `EXEC_FRAME_BYTES;
            wb_d.mem_rd = 1'b1;
            wb_d.mem_addr = issue_i.sp;
          end
          // Stores leave through the data bus only
          OP_STA_B, OP_STA_S, OP_STA_L, OP_STO_L:
          begin
            wb_d.valid = 1'b0;
            wb_d.we0 = 1'b0;
          end
          default: wb_d.we0 = 1'b0;
        endcase
      end
    endcase
  end

  // Frame values for the second step of call and return
  always_ff @(posedge clk_i)
  begin
    if (accept_i && step_i == STEP_READY)
    begin
      frame_sp_q <= issue_i.sp;
      frame_fp_q <= issue_i.fp;
      frame_pc_q <= issue_i.pc;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      wb_q <= '0;
    else
      wb_q <= accept_i ? wb_d : '0;
  end

  assign wb_o = wb_q;

  a_we_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_o.we0 || wb_o.we1) |-> wb_o.valid)
    else $error("register write enable on an invalid writeback record");

endmodule

// File: rtl/exec_isa_pkg.sv
// Form-1 moxie opcodes keep their values; decode maps form-2 ops to 7'h4x and branches to 7'h6x
package exec_isa_pkg;

  typedef enum logic [6:0] {
    OP_NOP    = 7'h00, OP_LDI_L  = 7'h01, OP_MOV    = 7'h02, OP_JSRA   = 7'h03,
    OP_RET    = 7'h04, OP_ADD_L  = 7'h05, OP_PUSH   = 7'h06, OP_POP    = 7'h07,
    OP_LDA_L  = 7'h08, OP_STA_L  = 7'h09, OP_LD_L   = 7'h0a, OP_ST_L   = 7'h0b,
    OP_LDO_L  = 7'h0c, OP_STO_L  = 7'h0d, OP_CMP    = 7'h0e, OP_SEX_B  = 7'h10,
    OP_SEX_S  = 7'h11, OP_ZEX_B  = 7'h12, OP_ZEX_S  = 7'h13, OP_BAD    = 7'h16,
    OP_JSR    = 7'h19, OP_JMPA   = 7'h1a, OP_LDI_B  = 7'h1b, OP_LD_B   = 7'h1c,
    OP_LDA_B  = 7'h1d, OP_ST_B   = 7'h1e, OP_STA_B  = 7'h1f, OP_LDI_S  = 7'h20,
    OP_LD_S   = 7'h21, OP_LDA_S  = 7'h22, OP_ST_S   = 7'h23, OP_STA_S  = 7'h24,
    OP_JMP    = 7'h25, OP_AND    = 7'h26, OP_LSHR   = 7'h27, OP_ASHL   = 7'h28,
    OP_SUB_L  = 7'h29, OP_NEG    = 7'h2a, OP_OR     = 7'h2b, OP_NOT    = 7'h2c,
    OP_ASHR   = 7'h2d, OP_XOR    = 7'h2e, OP_MUL_L  = 7'h2f, OP_SWI    = 7'h30,
    OP_DIV_L  = 7'h31, OP_UDIV_L = 7'h32, OP_MOD_L  = 7'h33, OP_UMOD_L = 7'h34,
    OP_BRK    = 7'h35, OP_LDO_B  = 7'h36, OP_STO_B  = 7'h37, OP_LDO_S  = 7'h38,
    OP_STO_S  = 7'h39,
    // Form 2, immediate in the step view
    OP_INC    = 7'h40, OP_DEC    = 7'h41, OP_GSR    = 7'h42, OP_SSR    = 7'h43,
    // Form 3, immediate in the branch view
    OP_BEQ    = 7'h60, OP_BNE    = 7'h61, OP_BLT    = 7'h62, OP_BGT    = 7'h63,
    OP_BLTU   = 7'h64, OP_BGTU   = 7'h65, OP_BGE    = 7'h66, OP_BLE    = 7'h67,
    OP_BGEU   = 7'h68, OP_BLEU   = 7'h69
  } exec_op_e;

  // Flags written by cmp, compared as reg_a against reg_b
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } exec_cc_t;

  // The 10-bit immediate field of form-2 and form-3 instructions
  typedef union packed {
    logic signed [9:0] br;
    struct packed {
      logic [1:0] pad;
      logic [7:0] amount;
    } step;
  } exec_imm_u;

endpackage

// File: rtl/exec_pipe_pkg.sv
// Loads carry only an address here; the memory stage supplies res0 for them
`include "exec_defines.svh"

package exec_pipe_pkg;

  typedef logic [3:0] exec_ridx_t;

  // Which part of a multi-cycle operation an accept belongs to
  typedef enum logic [1:0] {
    STEP_READY,
    STEP_FRAME2,
    STEP_RET2
  } exec_step_e;

  typedef struct packed {
    exec_isa_pkg::exec_op_e  op;
    logic [`EXEC_XLEN-1:0]   reg_a;
    logic [`EXEC_XLEN-1:0]   reg_b;
    logic [`EXEC_XLEN-1:0]   operand;
    exec_isa_pkg::exec_imm_u imm;
    exec_ridx_t              dst0;
    exec_ridx_t              dst1;
    logic [`EXEC_XLEN-1:0]   sp;
    logic [`EXEC_XLEN-1:0]   fp;
    logic [`EXEC_XLEN-1:0]   pc;
  } exec_issue_t;

  typedef struct packed {
    logic                  valid;
    logic                  we0;
    exec_ridx_t            idx0;
    logic [`EXEC_XLEN-1:0] res0;
    logic                  we1;
    exec_ridx_t            idx1;
    logic [`EXEC_XLEN-1:0] res1;
    logic                  mem_rd;
    logic                  mem_wr;
    logic [`EXEC_XLEN-1:0] mem_addr;
    logic [`EXEC_XLEN-1:0] mem_data;
    logic [`EXEC_XLEN-1:0] pc;
  } exec_wb_t;

  typedef struct packed {
    logic                  taken;
    logic [`EXEC_XLEN-1:0] target;
  } exec_branch_t;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [1:0]             sel;
    logic [`EXEC_XLEN-1:0]  addr;
    logic [`EXEC_BUS_W-1:0] data;
  } exec_dbus_req_t;

  // Beats is 1 or 2; a two-beat store sends the upper half first
  typedef struct packed {
    logic [`EXEC_XLEN-1:0] addr;
    logic [`EXEC_XLEN-1:0] data;
    logic [1:0]            beats;
    logic [1:0]            sel;
  } exec_store_t;

endpackage

// File: rtl/exec_sequencer.sv
// Decode must hold issue_i while busy_o is high; flush_i does not cancel an operation in progress
`timescale 1ns/1ns

module exec_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  exec_pipe_pkg::exec_issue_t issue_i,
  input  logic                       issue_stb_i,
  input  logic                       flush_i,
  input  logic                       taken_i,
  input  logic                       store_done_i,
  output logic                       accept_o,
  output exec_pipe_pkg::exec_step_e  step_o,
  output logic                       store_start_o,
  output exec_pipe_pkg::exec_store_t store_o,
  output logic                       flush_o,
  output logic                       busy_o
);
  import exec_pipe_pkg::*;
  import exec_isa_pkg::*;

  typedef enum logic [1:0] {
    ST_READY,
    ST_FRAME2,
    ST_RET2,
    ST_STORING
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       take_issue;
  logic       is_store;

  assign is_store = issue_i.op inside {OP_STA_B, OP_STA_S, OP_STA_L, OP_STO_L};

  // The slot after a taken branch is discarded, as is anything seen with flush_i
  assign take_issue = (state_q == ST_READY) && issue_stb_i && !taken_i && !flush_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_READY:
      begin
        if (take_issue)
        begin
          if (issue_i.op == OP_JSR || issue_i.op == OP_JSRA)
            state_d = ST_FRAME2;
          else if (issue_i.op == OP_RET)
            state_d = ST_RET2;
          else if (is_store)
            state_d = ST_STORING;
        end
      end
      ST_STORING:
      begin
        if (store_done_i)
          state_d = ST_READY;
      end
      default: state_d = ST_READY;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= ST_READY;
    else
      state_q <= state_d;
  end

  // Second steps run from values the units captured at the first step
  assign accept_o = take_issue || state_q == ST_FRAME2 || state_q == ST_RET2;

  always_comb
  begin
    case (state_q)
      ST_FRAME2: step_o = STEP_FRAME2;
      ST_RET2:   step_o = STEP_RET2;
      default:   step_o = STEP_READY;
    endcase
  end

  assign store_start_o = take_issue && is_store;

  always_comb
  begin
    store_o.addr = issue_i.operand;
    store_o.data = issue_i.reg_a;
    store_o.beats = 2'd1;
    store_o.sel = 2'b11;
    case (issue_i.op)
      OP_STA_B: store_o.sel = 2'b01;
      OP_STA_L: store_o.beats = 2'd2;
      OP_STO_L:
      begin
        store_o.addr = issue_i.operand + issue_i.reg_a;
        store_o.data = issue_i.reg_b;
        store_o.beats = 2'd2;
      end
      default: store_o.beats = 2'd1;
    endcase
  end

  assign flush_o = taken_i;
  assign busy_o = (state_q != ST_READY);

  a_no_start_while_storing: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == ST_STORING) |-> !store_start_o)
    else $error("new store started before the previous one finished");

endmodule

// File: rtl/exec_stage_top.sv
// No valid/ready handshake; busy_o is the only back-pressure and decode must honour it
`timescale 1ns/1ns

module exec_stage_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  exec_pipe_pkg::exec_issue_t    issue_i,
  input  logic                          issue_stb_i,
  input  logic                          flush_i,
  input  logic                          dbus_ack_i,
  output exec_pipe_pkg::exec_wb_t       wb_o,
  output exec_pipe_pkg::exec_branch_t   branch_o,
  output logic                          flush_o,
  output logic                          busy_o,
  output exec_pipe_pkg::exec_dbus_req_t dbus_o
);
  import exec_pipe_pkg::*;

  logic        accept;
  exec_step_e  step;
  logic        taken;
  logic        store_start;
  logic        store_done;
  exec_store_t store_job;

  exec_sequencer seq_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_i       (issue_i),
    .issue_stb_i   (issue_stb_i),
    .flush_i       (flush_i),
    .taken_i       (taken),
    .store_done_i  (store_done),
    .accept_o      (accept),
    .step_o        (step),
    .store_start_o (store_start),
    .store_o       (store_job),
    .flush_o       (flush_o),
    .busy_o        (busy_o)
  );

  exec_int_unit int_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .accept_i (accept),
    .step_i   (step),
    .issue_i  (issue_i),
    .wb_o     (wb_o)
  );

  exec_branch_unit br_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .accept_i (accept),
    .step_i   (step),
    .issue_i  (issue_i),
    .taken_o  (taken),
    .branch_o (branch_o)
  );

  exec_store_beats beats_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (store_start),
    .store_i    (store_job),
    .dbus_ack_i (dbus_ack_i),
    .dbus_o     (dbus_o),
    .done_o     (store_done)
  );

endmodule

// File: rtl/exec_store_beats.sv
// One store at a time; the bus may hold ack off indefinitely and read data is ignored
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_store_beats (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  exec_pipe_pkg::exec_store_t    store_i,
  input  logic                          dbus_ack_i,
  output exec_pipe_pkg::exec_dbus_req_t dbus_o,
  output logic                          done_o
);

  logic                  active_q;
  logic [1:0]            beats_left_q;
  logic [`EXEC_XLEN-1:0] addr_q;
  logic [`EXEC_XLEN-1:0] data_q;
  logic [1:0]            sel_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      active_q <= 1'b0;
      beats_left_q <= 2'd0;
    end
    else if (start_i)
    begin
      active_q <= 1'b1;
      beats_left_q <= store_i.beats;
    end
    else if (active_q && dbus_ack_i)
    begin
      beats_left_q <= beats_left_q - 2'd1;
      if (beats_left_q == 2'd1)
        active_q <= 1'b0;
    end
  end

  // Next beat goes one bus word higher
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      addr_q <= store_i.addr;
      data_q <= store_i.data;
      sel_q <= store_i.sel;
    end
    else if (active_q && dbus_ack_i)
      addr_q <= addr_q + `EXEC_BUS_W / 8;
  end

  always_comb
  begin
    dbus_o.cyc = active_q;
    dbus_o.stb = active_q;
    dbus_o.we = active_q;
    dbus_o.sel = sel_q;
    dbus_o.addr = addr_q;
    // Upper half first when two beats remain
    if (beats_left_q == 2'd2)
      dbus_o.data = data_q[`EXEC_XLEN-1:`EXEC_BUS_W];
    else
      dbus_o.data = data_q[`EXEC_BUS_W-1:0];
  end

  assign done_o = active_q && dbus_ack_i && (beats_left_q == 2'd1);

  a_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (dbus_o.stb && !dbus_ack_i) |=> dbus_o.stb && $stable(dbus_o.addr))
    else $error("data-bus address changed before acknowledge");

endmodule

// File: sim/tb_exec_stage.sv
// Directed tests only; loads are checked by address since the memory stage is not modelled
`timescale 1ns/1ns
`include "exec_defines.svh"

module tb_exec_stage;
  import exec_pipe_pkg::*;
  import exec_isa_pkg::*;

  localparam int NUM_TESTS = 7;
  localparam longint TIMEOUT_NS = NUM_TESTS * 200 * 40;
  localparam exec_op_e ALU_OPS [19] = '{OP_ADD_L, OP_SUB_L, OP_AND, OP_OR, OP_XOR, OP_ASHL,
    OP_ASHR, OP_LSHR, OP_MUL_L, OP_NEG, OP_NOT, OP_MOV, OP_SEX_B, OP_SEX_S, OP_ZEX_B,
    OP_ZEX_S, OP_LDI_L, OP_INC, OP_DEC};

  logic           clk_i;
  logic           rst_i;
  exec_issue_t    issue;
  logic           issue_stb;
  logic           flush_in;
  logic           dbus_ack;
  exec_wb_t       wb;
  exec_branch_t   branch;
  logic           flush_out;
  logic           busy;
  exec_dbus_req_t dbus;

  int    mismatches = 0;
  int    failures = 0;
  int    seed_ret;
  string test_name = "reset";

  exec_stage_top dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue_i     (issue),
    .issue_stb_i (issue_stb),
    .flush_i     (flush_in),
    .dbus_ack_i  (dbus_ack),
    .wb_o        (wb),
    .branch_o    (branch),
    .flush_o     (flush_out),
    .busy_o      (busy),
    .dbus_o      (dbus)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_wb(input string what, input exec_wb_t exp, input exec_wb_t act);
    if (act !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_branch(input string what, input exec_branch_t exp,
                              input exec_branch_t act);
    if (act !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_beat(input string what, input exec_dbus_req_t exp,
                            input exec_dbus_req_t act);
    if (act !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  function automatic exec_issue_t rand_issue(input exec_op_e op);
    exec_issue_t ins;
    ins.op = op;
    ins.reg_a = $urandom;
    ins.reg_b = $urandom;
    ins.operand = $urandom;
    ins.imm.br = 10'($urandom);
    ins.dst0 = 4'($urandom);
    ins.dst1 = 4'($urandom);
    ins.sp = $urandom & 32'hffff_fffc;
    ins.fp = $urandom;
    ins.pc = $urandom & 32'hffff_fffe;
    return ins;
  endfunction

  // Record with no register or memory effect
  function automatic exec_wb_t plain_record(input exec_issue_t ins);
    exec_wb_t r;
    r = '0;
    r.valid = 1'b1;
    r.idx0 = ins.dst0;
    r.idx1 = ins.dst1;
    r.pc = ins.pc;
    return r;
  endfunction

  function automatic logic [31:0] alu_result(input exec_issue_t ins);
    logic [31:0] a;
    logic [31:0] b;
    a = ins.reg_a;
    b = ins.reg_b;
    case (ins.op)
      OP_ADD_L: return a + b;
      OP_SUB_L: return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_ASHL:  return a << b;
      OP_ASHR:  return 32'($signed(a) >>> b);
      OP_LSHR:  return a >> b;
      OP_MUL_L: return a * b;
      OP_NEG:   return 32'd0 - b;
      OP_NOT:   return ~b;
      OP_MOV:   return b;
      OP_SEX_B: return 32'($signed(b[7:0]));
      OP_SEX_S: return 32'($signed(b[15:0]));
      OP_ZEX_B: return {24'd0, b[7:0]};
      OP_ZEX_S: return {16'd0, b[15:0]};
      OP_LDI_L: return ins.operand;
      OP_INC:   return a + {24'd0, ins.imm.step.amount};
      OP_DEC:   return a - {24'd0, ins.imm.step.amount};
      default:  return 32'd0;
    endcase
  endfunction

  // Flags compare reg_a against reg_b
  function automatic logic branch_rule(input exec_op_e op, input logic [31:0] a,
                                       input logic [31:0] b);
    logic slt;
    logic sgt;
    slt = $signed(a) < $signed(b);
    sgt = $signed(a) > $signed(b);
    case (op)
      OP_BEQ:  return a == b;
      OP_BNE:  return a != b;
      OP_BLT:  return slt;
      OP_BGT:  return sgt;
      OP_BLTU: return a < b;
      OP_BGTU: return a > b;
      OP_BGE:  return !slt;
      OP_BLE:  return !sgt;
      OP_BGEU: return a >= b;
      OP_BLEU: return a <= b;
      default: return 1'b0;
    endcase
  endfunction

  // Strobe for one cycle, return at the falling edge after the capture edge
  task automatic send(input exec_issue_t ins);
    issue = ins;
    issue_stb = 1'b1;
    @(negedge clk_i);
    issue_stb = 1'b0;
  endtask

  task automatic wait_idle(input string where);
    int n;
    n = 0;
    while (busy && n < 20)
    begin
      @(negedge clk_i);
      n++;
    end
    if (busy)
    begin
      failures++;
      $display("%s: busy_o never fell after %s", test_name, where);
    end
    else if (n != 0)
    begin
      failures++;
      $display("%s: busy_o stayed high %0d cycles too long after %s", test_name, n, where);
    end
  endtask

  // Holds ack low for a random time, then acknowledges one beat
  task automatic bus_beat(input logic [31:0] addr, input logic [15:0] data,
                          input logic [1:0] sel);
    exec_dbus_req_t exp;
    int d;
    int i;
    exp.cyc = 1'b1;
    exp.stb = 1'b1;
    exp.we = 1'b1;
    exp.sel = sel;
    exp.addr = addr;
    exp.data = data;
    d = $urandom % 4;
    for (i = 0; i < d; i++)
    begin
      check_beat("beat held", exp, dbus);
      @(negedge clk_i);
    end
    check_beat("beat", exp, dbus);
    dbus_ack = 1'b1;
    @(negedge clk_i);
    dbus_ack = 1'b0;
  endtask

  task automatic test_reset_state();
    test_name = "reset";
    check_flag("wb_o.valid", 1'b0, wb.valid);
    check_flag("branch_o.taken", 1'b0, branch.taken);
    check_flag("flush_o", 1'b0, flush_out);
    check_flag("busy_o", 1'b0, busy);
    check_flag("dbus_o.cyc", 1'b0, dbus.cyc);
    check_flag("dbus_o.stb", 1'b0, dbus.stb);
    check_flag("dbus_o.we", 1'b0, dbus.we);
  endtask

  task automatic test_alu();
    exec_issue_t ins;
    exec_wb_t exp;
    int k;
    int rep;
    test_name = "alu";
    for (k = 0; k < 19; k++)
    begin
      for (rep = 0; rep < 3; rep++)
      begin
        ins = rand_issue(ALU_OPS[k]);
        if (ins.op inside {OP_ASHL, OP_ASHR, OP_LSHR})
          ins.reg_b = $urandom % 40;
        exp = plain_record(ins);
        exp.we0 = 1'b1;
        exp.res0 = alu_result(ins);
        send(ins);
        check_wb(ins.op.name(), exp, wb);
      end
    end
    @(negedge clk_i);
    check_wb("idle after alu", '0, wb);
  endtask

  task automatic test_branches();
    exec_issue_t ins;
    exec_branch_t exp_br;
    logic [31:0] a;
    logic [31:0] b;
    int off;
    int n;
    int k;
    test_name = "branches";
    for (n = 0; n < 5; n++)
    begin
      a = $urandom;
      b = $urandom;
      case (n)
        0: b = a;
        1:
        begin
          a[31] = 1'b1;
          b[31] = 1'b0;
        end
        2:
        begin
          a[31] = 1'b0;
          b[31] = 1'b1;
        end
        default: b[31] = a[31];
      endcase
      for (k = 0; k < 10; k++)
      begin
        ins = rand_issue(OP_CMP);
        ins.reg_a = a;
        ins.reg_b = b;
        send(ins);
        check_wb("cmp record", plain_record(ins), wb);
        ins = rand_issue(exec_op_e'(7'(32'h60 + k)));
        send(ins);
        off = $signed(ins.imm.br);
        exp_br.taken = branch_rule(ins.op, a, b);
        exp_br.target = ins.pc + 32'(2 + 2 * off);
        check_branch(ins.op.name(), exp_br, branch);
        check_flag("flush_o", exp_br.taken, flush_out);
        check_wb("branch record", plain_record(ins), wb);
        // Idle slot so a taken branch does not discard the next cmp
        @(negedge clk_i);
      end
    end
  endtask

  task automatic test_discard();
    exec_issue_t ins;
    exec_wb_t exp;
    exec_branch_t exp_br;
    test_name = "discard";
    ins = rand_issue(OP_JMPA);
    send(ins);
    exp_br.taken = 1'b1;
    exp_br.target = ins.operand;
    check_branch("jmpa", exp_br, branch);
    check_flag("flush_o", 1'b1, flush_out);
    ins = rand_issue(OP_ADD_L);
    send(ins);
    check_wb("issue after jmpa", '0, wb);
    flush_in = 1'b1;
    send(ins);
    flush_in = 1'b0;
    check_wb("issue with flush_i", '0, wb);
    exp = plain_record(ins);
    exp.we0 = 1'b1;
    exp.res0 = ins.reg_a + ins.reg_b;
    send(ins);
    check_wb("issue after flush", exp, wb);
  endtask

  task automatic test_stores();
    exec_issue_t ins;
    int n;
    test_name = "stores";
    for (n = 0; n < 3; n++)
    begin
      ins = rand_issue(OP_STA_L);
      send(ins);
      check_flag("busy_o at start", 1'b1, busy);
      check_flag("no writeback", 1'b0, wb.valid);
      bus_beat(ins.operand, ins.reg_a[31:16], 2'b11);
      bus_beat(ins.operand + 32'd2, ins.reg_a[15:0], 2'b11);
      wait_idle("sta.l");
      check_flag("stb after last beat", 1'b0, dbus.stb);
    end
    ins = rand_issue(OP_STA_B);
    send(ins);
    check_flag("busy_o at start", 1'b1, busy);
    bus_beat(ins.operand, ins.reg_a[15:0], 2'b01);
    wait_idle("sta.b");
    check_flag("stb after byte store", 1'b0, dbus.stb);
  endtask

  task automatic test_frames();
    exec_issue_t ins;
    exec_wb_t exp;
    exec_branch_t exp_br;
    int k;
    test_name = "frames";
    for (k = 0; k < 2; k++)
    begin
      ins = rand_issue(k == 0 ? OP_JSR : OP_JSRA);
      send(ins);
      exp = plain_record(ins);
      exp.we0 = 1'b1;
      exp.idx0 = 4'(`EXEC_SP_IDX);
      exp.res0 = ins.sp - 32'd8;
      exp.mem_wr = 1'b1;
      exp.mem_addr = ins.sp - 32'd8;
      exp.mem_data = ins.pc + (k == 0 ? 32'd2 : 32'd6);
      check_wb("call first slot", exp, wb);
      check_flag("busy_o in first slot", 1'b1, busy);
      check_flag("taken in first slot", 1'b0, branch.taken);
      @(negedge clk_i);
      exp.res0 = ins.sp - 32'd4;
      exp.mem_addr = ins.sp - 32'd4;
      exp.mem_data = ins.fp;
      check_wb("call second slot", exp, wb);
      exp_br.taken = 1'b1;
      exp_br.target = (k == 0) ? ins.reg_a : ins.operand;
      check_branch("call target", exp_br, branch);
      check_flag("busy_o in second slot", 1'b0, busy);
      @(negedge clk_i);
    end
    ins = rand_issue(OP_RET);
    send(ins);
    exp = plain_record(ins);
    exp.we0 = 1'b1;
    exp.idx0 = 4'(`EXEC_SP_IDX);
    exp.res0 = ins.sp + 32'd8;
    exp.mem_rd = 1'b1;
    exp.mem_addr = ins.sp;
    check_wb("ret first read", exp, wb);
    check_flag("busy_o in ret", 1'b1, busy);
    @(negedge clk_i);
    exp = plain_record(ins);
    exp.mem_rd = 1'b1;
    exp.mem_addr = ins.sp + 32'd4;
    check_wb("ret second read", exp, wb);
  endtask

  task automatic test_stack();
    exec_issue_t ins;
    exec_wb_t exp;
    test_name = "stack";
    ins = rand_issue(OP_PUSH);
    send(ins);
    exp = plain_record(ins);
    exp.we0 = 1'b1;
    exp.res0 = ins.reg_a - 32'd4;
    exp.mem_wr = 1'b1;
    exp.mem_addr = ins.reg_a - 32'd4;
    exp.mem_data = ins.reg_b;
    check_wb("push", exp, wb);
    ins = rand_issue(OP_POP);
    send(ins);
    exp = plain_record(ins);
    exp.we0 = 1'b1;
    exp.we1 = 1'b1;
    exp.idx0 = ins.dst1;
    exp.idx1 = ins.dst0;
    exp.res1 = ins.reg_a - 32'd4;
    exp.mem_rd = 1'b1;
    exp.mem_addr = ins.reg_a;
    check_wb("pop", exp, wb);
    ins = rand_issue(OP_LDO_L);
    send(ins);
    exp = plain_record(ins);
    exp.we0 = 1'b1;
    exp.mem_rd = 1'b1;
    exp.mem_addr = ins.operand + ins.reg_b;
    check_wb("ldo.l", exp, wb);
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("Run stopped by the watchdog after %0d ns in %s", TIMEOUT_NS, test_name);
    $display("test failed");
    $finish;
  end

  initial
  begin
    seed_ret = $urandom(32'hdb664f71);
    clk_i = 1'b0;
    rst_i = 1'b1;
    issue = '0;
    issue_stb = 1'b0;
    flush_in = 1'b0;
    dbus_ack = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_reset_state();
    test_alu();
    test_branches();
    test_discard();
    test_stores();
    test_frames();
    test_stack();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
